// ==== hw/rv_exec_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I execution slice shared types
// Opcodes, control enums, stage payloads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rv_exec_pkg;

  localparam int xlen = 32; // RV32 only

  // Base opcodes handled by the slice
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;

  // Branch conditions, funct3 encoding
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and,
    alu_pass_b                              // LUI, operand B straight through
  } alu_op_e;

  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_sel_e;

  typedef enum logic {wb_alu, wb_pc4} wb_sel_e; // ALU result or link

  typedef struct packed {
    logic       reg_write;
    logic       branch;
    logic       jump;
    logic       alu_src;   // Operand B is the immediate
    logic       pc_src;    // Operand A is pc (AUIPC)
    logic       jalr;      // Jump base is rs1
    alu_op_e    alu_op;
    wb_sel_e    wb_sel;
    imm_sel_e   imm_sel;
    logic [2:0] funct3;    // Branch condition
    logic       illegal;
  } ctrl_t;

  // Decode to execute
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] imm;
    logic [4:0]      rd;
    ctrl_t           ctrl;
  } dec_bundle_t;

  // Execute to result
  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic [xlen-1:0] data;
    logic            write;    // Qualified, rd nonzero and legal
    logic            illegal;
    logic            redirect;
    logic [xlen-1:0] target;
  } ex_result_t;

endpackage

`default_nettype wire

// ==== hw/control_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control unit
// Opcode and funct decode into ctrl_t
// Unsupported encodings flag illegal
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module control_unit import rv_exec_pkg::*; (
  input  logic [31:0] instr,
  output ctrl_t       ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // ALU op from funct3, funct7[5] picks SUB (reg only) and SRA/SRAI
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic f7b5,
                                      input logic is_reg);
    case (f3)
      3'b000:  alu_sel = (is_reg && f7b5) ? alu_sub : alu_add;
      3'b001:  alu_sel = alu_sll;
      3'b010:  alu_sel = alu_slt;
      3'b011:  alu_sel = alu_sltu;
      3'b100:  alu_sel = alu_xor;
      3'b101:  alu_sel = f7b5 ? alu_sra : alu_srl;
      3'b110:  alu_sel = alu_or;
      default: alu_sel = alu_and;
    endcase
  endfunction

  always_comb begin
    ctrl        = '0;            // Everything inactive
    ctrl.funct3 = funct3;
    case (opcode)
      op_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = alu_pass_b;
        ctrl.imm_sel   = imm_u;
      end
      op_auipc: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.pc_src    = 1'b1;   // pc + imm_u
        ctrl.imm_sel   = imm_u;
      end
      op_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.wb_sel    = wb_pc4;
        ctrl.imm_sel   = imm_j;
      end
      op_jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.jalr      = 1'b1;
        ctrl.wb_sel    = wb_pc4;
        ctrl.imm_sel   = imm_i;
        ctrl.illegal   = (funct3 != 3'b000);
      end
      op_branch: begin
        ctrl.branch  = 1'b1;
        ctrl.imm_sel = imm_b;
        ctrl.illegal = (funct3 == 3'b010) || (funct3 == 3'b011); // No such branch
      end
      op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = alu_sel(funct3, funct7[5], 1'b0);
        // Shift immediates carry funct7 in the upper imm bits
        if (funct3 == 3'b001)
          ctrl.illegal = (funct7 != 7'b0000000);
        else if (funct3 == 3'b101)
          ctrl.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
      end
      op_op: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_sel(funct3, funct7[5], 1'b1);
        // Only ADD/SUB and SRL/SRA have an alternate funct7
        ctrl.illegal = !((funct7 == 7'b0000000) ||
                         (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      default: ctrl.illegal = 1'b1; // Loads, stores, SYSTEM, M/A, unknown
    endcase
    if (ctrl.illegal) begin
      ctrl.reg_write = 1'b0;     // No side effects
      ctrl.branch    = 1'b0;
      ctrl.jump      = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage
// Field split, immediate, operand bypass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_exec_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            instr_valid,
  input  logic [31:0]     instr,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  ex_result_t      ex_now,
  input  logic            wb_valid,
  input  logic [4:0]      wb_rd,
  input  logic [xlen-1:0] wb_data,
  output logic [4:0]      rs1_addr,
  output logic [4:0]      rs2_addr,
  output dec_bundle_t     dec
);

  ctrl_t           ctrl;
  logic [xlen-1:0] imm;
  dec_bundle_t     dec_next;

  control_unit u_ctrl (.instr(instr), .ctrl(ctrl));

  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  always_comb begin
    case (ctrl.imm_sel)
      imm_i:   imm = {{20{instr[31]}}, instr[31:20]};
      imm_s:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      imm_b:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      imm_u:   imm = {instr[31:12], 12'b0};
      imm_j:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  // Newest producer first: execute, then write-back, then register file
  function automatic logic [xlen-1:0] bypass(input logic [4:0] addr,
                                             input logic [xlen-1:0] rf,
                                             input ex_result_t exn,
                                             input logic wv,
                                             input logic [4:0] wr,
                                             input logic [xlen-1:0] wd);
    if (addr == 5'd0)
      bypass = '0;                                        // x0
    else if (exn.valid && exn.write && exn.rd == addr)
      bypass = exn.data;                                  // One slot ahead
    else if (wv && wr == addr)
      bypass = wd;                                        // Two slots ahead
    else
      bypass = rf;
  endfunction

  always_comb begin
    dec_next.valid = instr_valid;
    dec_next.pc    = pc;
    dec_next.rs1   = bypass(rs1_addr, rs1_data, ex_now, wb_valid, wb_rd, wb_data);
    dec_next.rs2   = bypass(rs2_addr, rs2_data, ex_now, wb_valid, wb_rd, wb_data);
    dec_next.imm   = imm;
    dec_next.rd    = instr[11:7];
    dec_next.ctrl  = ctrl;
  end

  always_ff @(posedge clk) begin
    dec <= dec_next;
    if (reset)
      dec.valid <= 1'b0;  // Payload left as is
  end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage
// ALU, branch resolve, jump target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv_exec_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  dec_bundle_t dec,
  output ex_result_t  ex_now,  // Combinational, feeds decode bypass
  output ex_result_t  ex
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] link;
  logic [xlen-1:0] jalr_sum;
  logic            eq;
  logic            lt;
  logic            ltu;
  logic            taken;

  assign op_a = dec.ctrl.pc_src  ? dec.pc  : dec.rs1;
  assign op_b = dec.ctrl.alu_src ? dec.imm : dec.rs2;

  always_comb begin
    case (dec.ctrl.alu_op)
      alu_add:    alu_res = op_a + op_b;
      alu_sub:    alu_res = op_a - op_b;
      alu_sll:    alu_res = op_a << op_b[4:0];
      alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    alu_res = op_a ^ op_b;
      alu_srl:    alu_res = op_a >> op_b[4:0];
      alu_sra:    alu_res = $signed(op_a) >>> op_b[4:0];  // Sign fill
      alu_or:     alu_res = op_a | op_b;
      alu_and:    alu_res = op_a & op_b;
      alu_pass_b: alu_res = op_b;                        // LUI
      default:    alu_res = '0;
    endcase
  end

  // Branch compare always on the two register operands
  assign eq  = (dec.rs1 == dec.rs2);
  assign lt  = ($signed(dec.rs1) < $signed(dec.rs2));
  assign ltu = (dec.rs1 < dec.rs2);

  always_comb begin
    case (dec.ctrl.funct3)
      f3_beq:  taken = eq;
      f3_bne:  taken = !eq;
      f3_blt:  taken = lt;
      f3_bge:  taken = !lt;
      f3_bltu: taken = ltu;
      f3_bgeu: taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  assign link     = dec.pc + 32'd4;
  assign jalr_sum = dec.rs1 + dec.imm;

  always_comb begin
    ex_now.valid    = dec.valid;
    ex_now.rd       = dec.rd;
    ex_now.data     = (dec.ctrl.wb_sel == wb_pc4) ? link : alu_res;
    ex_now.write    = dec.ctrl.reg_write && !dec.ctrl.illegal && (dec.rd != 5'd0);
    ex_now.illegal  = dec.ctrl.illegal;
    ex_now.redirect = dec.ctrl.jump || (dec.ctrl.branch && taken);
    // JALR drops bit 0 of the sum
    ex_now.target   = dec.ctrl.jalr ? {jalr_sum[xlen-1:1], 1'b0} : dec.pc + dec.imm;
  end

  always_ff @(posedge clk) begin
    ex <= ex_now;
    if (reset)
      ex.valid <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== hw/result_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result stage
// Register file and write-back outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module result_stage import rv_exec_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  ex_result_t      ex,
  input  logic [4:0]      rs1_addr,
  input  logic [4:0]      rs2_addr,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data,
  output logic            wb_valid,
  output logic [4:0]      wb_rd,
  output logic [xlen-1:0] wb_data,
  output logic            redirect,
  output logic [xlen-1:0] redirect_target,
  output logic            illegal
);

  logic [xlen-1:0] regs [1:31]; // x1..x31, x0 is not stored

  // Outputs come straight from the ex register
  assign wb_valid        = ex.valid && ex.write;
  assign wb_rd           = ex.rd;
  assign wb_data         = ex.data;
  assign redirect        = ex.valid && ex.redirect;
  assign redirect_target = ex.target;
  assign illegal         = ex.valid && ex.illegal;

  // Commit at the edge closing the write-back cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end else if (wb_valid) begin
      regs[wb_rd] <= wb_data;  // wb_rd never 0 here
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== hw/rv_exec_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I execution slice, top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top import rv_exec_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            instr_valid,
  input  logic [31:0]     instr,
  input  logic [xlen-1:0] pc,
  output logic            wb_valid,
  output logic [4:0]      wb_rd,
  output logic [xlen-1:0] wb_data,
  output logic            redirect,
  output logic [xlen-1:0] redirect_target,
  output logic            illegal
);

  dec_bundle_t     dec;
  ex_result_t      ex_now;
  ex_result_t      ex;
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;

  decode_stage u_decode (
    .clk, .reset, .instr_valid, .instr, .pc,
    .rs1_data, .rs2_data, .ex_now,
    .wb_valid, .wb_rd, .wb_data,           // Write-back bypass
    .rs1_addr, .rs2_addr, .dec
  );

  execute_stage u_execute (.clk, .reset, .dec, .ex_now, .ex);

  result_stage u_result (
    .clk, .reset, .ex, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .wb_valid, .wb_rd, .wb_data, .redirect, .redirect_target, .illegal
  );

endmodule

`default_nettype wire

// ==== testbench/rv_exec_properties.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timing properties of rv_exec_top
// Bound into the DUT, two-cycle latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rv_exec_properties (
  input logic       clk,
  input logic       reset,
  input logic       instr_valid,
  input logic       wb_valid,
  input logic [4:0] wb_rd,
  input logic       redirect,
  input logic       illegal
);

  // Anything sampled while in reset is dropped before the outputs
  quiet_after_reset: assert property (@(posedge clk)
    $past(reset, 2) |-> !wb_valid && !redirect && !illegal)
    else $error("output active within two cycles of reset");

  // Any result traces back to an issue two edges earlier
  result_latency: assert property (@(posedge clk) disable iff (reset)
    (wb_valid || redirect || illegal) |-> $past(instr_valid, 2))
    else $error("output active without an instruction two cycles earlier");

  wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> wb_rd != 5'd0)
    else $error("write-back reported for x0");

  // Illegal instructions never write
  illegal_no_write: assert property (@(posedge clk) disable iff (reset)
    !(wb_valid && illegal))
    else $error("illegal and wb_valid high together");

endmodule

bind rv_exec_top rv_exec_properties props (
  .clk(clk), .reset(reset), .instr_valid(instr_valid), .wb_valid(wb_valid),
  .wb_rd(wb_rd), .redirect(redirect), .illegal(illegal)
);

`default_nettype wire

// ==== testbench/tb_rv_exec.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the RV32I execution slice
// Random program against a shadow model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

  typedef struct packed {
    logic        wb_valid;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        redirect;
    logic [31:0] target;
    logic        illegal;
  } expect_t;

  localparam logic [6:0] opc_imm = 7'b0010011;

  logic        clk;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        redirect;
  logic [31:0] redirect_target;
  logic        illegal;

  logic [31:0] seed = 32'hf60fd566;
  logic [31:0] shadow [0:31];       // Model register file
  logic [31:0] prog_instr [$];
  logic        prog_valid [$];
  string       prog_name [$];
  expect_t     expected [$];        // One entry per issue slot
  int          errors = 0;
  int          limit_cycles = 0;

  rv_exec_top DUT (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] rnd();
    seed = xorshift(seed);
    return seed;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // RV32I arithmetic per funct3, alt is funct7 bit 5
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt)
          return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Applies one instruction to the shadow file, returns what the DUT must show
  task automatic model(input logic [31:0] ins, input logic [31:0] p, output expect_t e);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] res;
    logic        wr;
    a     = shadow[ins[19:15]];
    b     = shadow[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    e     = '0;
    e.rd  = ins[11:7];
    wr    = 1'b1;
    res   = '0;
    case (ins[6:0])
      7'b0110111: res = {ins[31:12], 12'b0};            // LUI
      7'b0010111: res = p + {ins[31:12], 12'b0};        // AUIPC
      7'b1101111: begin
        res        = p + 32'd4;
        e.redirect = 1'b1;
        e.target   = p + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'b1100111: begin
        res        = p + 32'd4;
        e.redirect = 1'b1;
        e.target   = (a + imm_i) & ~32'd1;              // Bit 0 dropped
      end
      7'b1100011: begin
        wr         = 1'b0;
        e.redirect = branch_ref(ins[14:12], a, b);
        e.target   = p + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      7'b0010011: res = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
      7'b0110011: res = alu_ref(ins[14:12], ins[30], a, b);
      default: begin
        wr        = 1'b0;
        e.illegal = 1'b1;
      end
    endcase
    e.wb_valid = wr && e.rd != 5'd0;
    e.data     = res;
    if (e.wb_valid)
      shadow[e.rd] = res;
  endtask

  task automatic add_instr(input string name, input logic [31:0] ins);
    prog_valid.push_back(1'b1);
    prog_instr.push_back(ins);
    prog_name.push_back(name);
  endtask

  task automatic add_bubble();
    prog_valid.push_back(1'b0);
    prog_instr.push_back(rnd());    // Junk while idle
    prog_name.push_back("idle");
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic        alt;
    logic [2:0]  conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    add_bubble();
    add_bubble();
    for (int i = 1; i <= 8; i++) begin     // LUI then dependent ADDI
      r = rnd();
      add_instr("lui", u_type(r[31:12], 5'(i), 7'b0110111));
      add_instr("addi", i_type(r[11:0], 5'(i), 3'd0, 5'(i), opc_imm));
    end
    for (int i = 0; i < 60; i++) begin
      r   = rnd();
      f3  = r[2:0];
      alt = r[3];
      if (r[16]) begin
        add_instr("op", r_type((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                               {1'b0, r[15:12]}, {1'b0, r[11:8]}, f3, {1'b0, r[7:4]}));
      end else begin
        imm = r[31:20];
        if (f3 == 3'd1)
          imm[11:5] = 7'h00;
        if (f3 == 3'd5)
          imm[11:5] = alt ? 7'h20 : 7'h00;      // SRAI or SRLI
        add_instr("op_imm", i_type(imm, {1'b0, r[11:8]}, f3, {1'b0, r[7:4]}, opc_imm));
      end
    end
    for (int gap = 1; gap <= 3; gap++) begin  // Producer 1, 2, 3 slots ahead
      r = rnd();
      // Older x20 value that the producer overrides
      add_instr("stale", i_type(~r[11:0], 5'd1, 3'd0, 5'd20, opc_imm));
      add_instr("producer", i_type(r[11:0], 5'd1, 3'd0, 5'd20, opc_imm));
      for (int f = 1; f < gap; f++)
        add_instr("x0_write", i_type(12'd0, 5'd0, 3'd0, 5'd0, opc_imm));
      add_instr("bypass_rs1", r_type(7'h20, 5'd2, 5'd20, 3'd0, 5'd21));
      add_instr("bypass_rs2", r_type(7'h00, 5'd20, 5'd3, 3'd0, 5'd22));
    end
    r = rnd();
    add_instr("lui", u_type({1'b1, r[18:0]}, 5'd6, 7'b0110111));  // x6 negative
    add_instr("addi", i_type(12'd100, 5'd0, 3'd0, 5'd7, opc_imm)); // x7 small positive
    for (int i = 0; i < 6; i++) begin
      r = rnd();
      add_instr("branch_eq", b_type({r[12:1], 1'b0}, 5'd5, 5'd5, conds[i]));
      add_instr("branch_lt", b_type({r[12:1], 1'b0}, 5'd7, 5'd6, conds[i]));
      add_instr("branch_gt", b_type({r[12:1], 1'b0}, 5'd6, 5'd7, conds[i]));
    end
    r = rnd();
    add_instr("jal", j_type({r[20:1], 1'b0}, 5'd9));
    add_instr("jalr", i_type(r[31:20], 5'd9, 3'd0, 5'd10, 7'b1100111));
    add_instr("jal_x0", j_type({r[30:11], 1'b0}, 5'd0));
    add_instr("auipc", u_type(r[31:12], 5'd11, 7'b0010111));
    add_instr("load", i_type(12'd4, 5'd1, 3'd2, 5'd12, 7'b0000011));
    add_instr("store", {7'd0, 5'd2, 5'd1, 3'd2, 5'd0, 7'b0100011});
    add_instr("system", 32'h00000073);                              // ECALL
    add_instr("unknown", {25'd0, 7'b1111111});
    add_instr("after_illegal", r_type(7'h00, 5'd0, 5'd12, 3'd0, 5'd13)); // x12 untouched
    add_bubble();
  endtask

  task automatic report_mismatch(input string name, input string field,
                                 input logic [31:0] exp_v, input logic [31:0] act_v);
    errors++;
    $display("mismatch %s %s expected %h actual %h", name, field, exp_v, act_v);
  endtask

  task automatic check(input string name, input expect_t e);
    assert (wb_valid == e.wb_valid)
      else report_mismatch(name, "wb_valid", 32'(e.wb_valid), 32'(wb_valid));
    if (e.wb_valid) begin
      assert (wb_rd == e.rd) else report_mismatch(name, "wb_rd", 32'(e.rd), 32'(wb_rd));
      assert (wb_data == e.data) else report_mismatch(name, "wb_data", e.data, wb_data);
    end
    assert (redirect == e.redirect)
      else report_mismatch(name, "redirect", 32'(e.redirect), 32'(redirect));
    if (e.redirect) begin
      assert (redirect_target == e.target)
        else report_mismatch(name, "redirect_target", e.target, redirect_target);
    end
    assert (illegal == e.illegal)
      else report_mismatch(name, "illegal", 32'(e.illegal), 32'(illegal));
  endtask

  // Watchdog, armed once the program length is known
  initial begin
    wait (limit_cycles > 0);
    #(limit_cycles * 100);
    $display("watchdog expired after %0d cycles, program never drained", limit_cycles);
    $display("sim failed");
    $finish;
  end

  initial begin
    expect_t e;
    clk         = 1'b0;
    reset       = 1'b1;
    instr_valid = 1'b1;                 // Reset must swallow this JAL
    instr       = j_type(21'd8, 5'd1);
    pc          = '0;
    for (int i = 0; i < 32; i++)
      shadow[i] = '0;
    build_program();
    limit_cycles = prog_instr.size() + 20;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int k = 0; k < prog_instr.size() + 2; k++) begin
      if (k >= 2)
        check(prog_name[k-2], expected[k-2]);   // Issued two edges back
      if (k < prog_instr.size()) begin
        instr_valid = prog_valid[k];
        instr       = prog_instr[k];
        pc          = 32'h1000 + 32'(4 * k);
        e           = '0;
        if (prog_valid[k])
          model(instr, pc, e);
        expected.push_back(e);
      end else begin
        instr_valid = 1'b0;
      end
      @(negedge clk);
    end
    $display("checks done, %0d errors", errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_exec.f ====
hw/rv_exec_pkg.sv
hw/control_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/rv_exec_top.sv
testbench/rv_exec_properties.sv
testbench/tb_rv_exec.sv

// ==== Makefile ====
# Verilator build and run for the RV32I execution slice

TOP = tb_rv_exec
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f rv_exec.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "FAIL: run ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
